//--- src/tcb_lite_consts.svh
// TCB lite width, delay and depth constants
// shared by the package and the RTL modules

`ifndef TCB_LITE_CONSTS_SVH
`define TCB_LITE_CONSTS_SVH

// byte address width
`define TCB_ADR_W 12

// data width and number of byte lanes
`define TCB_DAT_W 32
`define TCB_BYT_W (`TCB_DAT_W/8)

// width of the log2 transfer size code
`define TCB_SIZ_W 2

// memory read delay in cycles, must be at least 1
`define TCB_DELAY 1

// memory depth in words, covers the whole address space
`define TCB_MEM_WORDS 1024

// error counter width
`define TCB_CNT_W 16

`endif

//--- src/tcb_lite_pkg.sv
// TCB lite types
// vector typedefs, lane mode enum, request and response structs

`include "tcb_lite_consts.svh"

package tcb_lite_pkg;

    //////////////////////////////
    // vectors
    //////////////////////////////

    // byte address
    typedef logic [`TCB_ADR_W-1:0] adr_t;
    // write / read data
    typedef logic [`TCB_DAT_W-1:0] dat_t;
    // byte enable mask, one bit per lane
    typedef logic [`TCB_BYT_W-1:0] byt_t;
    // log2 size, 0 byte, 1 half-word, 2 word
    typedef logic [`TCB_SIZ_W-1:0] siz_t;
    // error response count
    typedef logic [`TCB_CNT_W-1:0] cnt_t;

    // read lane selection mode
    typedef enum logic {
        LANE_LOG = 1'b0,
        LANE_BYT = 1'b1
    } mode_t;

    //////////////////////////////
    // bus structs
    //////////////////////////////

    // manager to subordinate
    typedef struct packed {
        logic vld;
        logic wen;
        logic lck;
        adr_t adr;
        siz_t siz;
        byt_t byt;
        dat_t wdt;
    } tcb_req_t;

    // subordinate to manager
    typedef struct packed {
        dat_t rdt;
        logic err;
        logic rdy;
    } tcb_rsp_t;

endpackage

//--- src/tcb_lite_config.sv
// TCB lite configuration block
// lane mode and address limit registers, saturating error counter

module tcb_lite_config (
    input  logic                man,
    input  logic                rst,
    // register write port
    input  logic                cfg_we,
    input  tcb_lite_pkg::mode_t cfg_mode,
    input  tcb_lite_pkg::adr_t  cfg_limit,
    // one pulse per error response
    input  logic                rsp_err_pulse,
    output tcb_lite_pkg::mode_t mode,
    output tcb_lite_pkg::adr_t  limit,
    output tcb_lite_pkg::cnt_t  err_count
);

    //////////////////////////////
    // settings
    //////////////////////////////

    // log size lanes and an all-ones limit after reset
    always_ff @(posedge man) begin
        if (rst) begin
            mode  <= tcb_lite_pkg::LANE_LOG;
            limit <= '1;
        end else if (cfg_we) begin
            mode  <= cfg_mode;
            limit <= cfg_limit;
        end
    end

    //////////////////////////////
    // error counter
    //////////////////////////////

    // sticks at the top value
    always_ff @(posedge man) begin
        if (rst) begin
            err_count <= '0;
        end else if (rsp_err_pulse && (err_count != '1)) begin
            err_count <= err_count + 1'b1;
        end
    end

endmodule

//--- src/tcb_lite_register_response.sv
// TCB lite response register slice
// request passthrough, accept delay line, lane-masked read data register

`include "tcb_lite_consts.svh"

module tcb_lite_register_response (
    input  logic                  man,
    input  logic                  rst,
    input  tcb_lite_pkg::tcb_req_t req_sub,
    output tcb_lite_pkg::tcb_req_t req_man,
    input  tcb_lite_pkg::tcb_rsp_t rsp_man,
    output tcb_lite_pkg::tcb_rsp_t rsp_sub,
    input  tcb_lite_pkg::mode_t    mode,
    output logic                  rsp_err_pulse
);

    localparam int unsigned DLY = `TCB_DELAY;

    // what the response edge needs to know about a transfer
    typedef struct packed {
        logic               vld;
        logic               wen;
        tcb_lite_pkg::siz_t siz;
        tcb_lite_pkg::byt_t byt;
    } dly_t;

    dly_t               dly_q [0:DLY-1];
    dly_t               dly_out;
    logic               acc;
    tcb_lite_pkg::byt_t lane_en;
    tcb_lite_pkg::dat_t rdt_q;
    logic               err_q;

    //////////////////////////////
    // request path
    //////////////////////////////

    // request goes straight through
    assign req_man = req_sub;

    // transfer accepted on this edge
    assign acc = req_sub.vld & rsp_man.rdy;

    //////////////////////////////
    // accept delay line
    //////////////////////////////

    // stage 0 loads on the accept edge, last stage marks the response edge
    always_ff @(posedge man) begin
        if (rst) begin
            for (int unsigned i = 0; i < DLY; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= '{vld: acc, wen: req_sub.wen, siz: req_sub.siz, byt: req_sub.byt};
            for (int unsigned i = 1; i < DLY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign dly_out = dly_q[DLY-1];

    // read lanes that get updated, mode taken at the response edge
    always_comb begin
        for (int unsigned i = 0; i < `TCB_BYT_W; i++) begin
            if (mode == tcb_lite_pkg::LANE_LOG) begin
                // lanes below 2**siz
                lane_en[i] = (i < (32'd1 << dly_out.siz));
            end else begin
                lane_en[i] = dly_out.byt[i];
            end
        end
    end

    //////////////////////////////
    // response register
    //////////////////////////////

    always_ff @(posedge man) begin
        if (rst) begin
            rdt_q         <= '0;
            err_q         <= 1'b0;
            rsp_err_pulse <= 1'b0;
        end else begin
            rsp_err_pulse <= dly_out.vld & rsp_man.err;
            if (dly_out.vld) begin
                err_q <= rsp_man.err;
                // write responses leave read data alone
                if (!dly_out.wen) begin
                    for (int unsigned i = 0; i < `TCB_BYT_W; i++) begin
                        if (lane_en[i]) rdt_q[i*8 +: 8] <= rsp_man.rdt[i*8 +: 8];
                    end
                end
            end
        end
    end

    // rdy is not registered
    assign rsp_sub = '{rdt: rdt_q, err: err_q, rdy: rsp_man.rdy};

endmodule

//--- src/tcb_lite_memory.sv
// TCB lite SRAM subordinate
// byte lane writes, fixed read delay, address limit errors

`include "tcb_lite_consts.svh"

module tcb_lite_memory (
    input  logic                  man,
    input  logic                  rst,
    input  tcb_lite_pkg::tcb_req_t req,
    input  tcb_lite_pkg::adr_t     limit,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    localparam int unsigned DLY   = `TCB_DELAY;
    // byte offset bits inside a word
    localparam int unsigned OFS_W = $clog2(`TCB_BYT_W);

    tcb_lite_pkg::dat_t mem [0:`TCB_MEM_WORDS-1];

    logic                         rdy_q;
    logic                         acc;
    logic                         over;
    logic [`TCB_ADR_W-OFS_W-1:0]  idx;
    tcb_lite_pkg::dat_t           rdt_d;

    // response pipeline
    tcb_lite_pkg::dat_t           pip_rdt [0:DLY-1];
    logic                         pip_err [0:DLY-1];

    //////////////////////////////
    // handshake and decode
    //////////////////////////////

    // always ready once out of reset
    always_ff @(posedge man) begin
        if (rst) begin
            rdy_q <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
        end
    end

    assign acc  = req.vld & rdy_q;
    // at or above the limit is an error
    assign over = (req.adr >= limit);
    // word address
    assign idx  = req.adr[`TCB_ADR_W-1:OFS_W];

    //////////////////////////////
    // storage
    //////////////////////////////

    // cleared on reset, writes skipped on error
    always_ff @(posedge man) begin
        if (rst) begin
            for (int unsigned i = 0; i < `TCB_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (acc && req.wen && !over) begin
            for (int unsigned b = 0; b < `TCB_BYT_W; b++) begin
                if (req.byt[b]) mem[idx][b*8 +: 8] <= req.wdt[b*8 +: 8];
            end
        end
    end

    // full word on reads, zero on writes and errors
    assign rdt_d = (req.wen || over) ? '0 : mem[idx];

    //////////////////////////////
    // read delay pipeline
    //////////////////////////////

    // error flags of accepted transfers
    always_ff @(posedge man) begin
        if (rst) begin
            for (int unsigned i = 0; i < DLY; i++) begin
                pip_err[i] <= 1'b0;
            end
        end else begin
            pip_err[0] <= acc & over;
            for (int unsigned i = 1; i < DLY; i++) begin
                pip_err[i] <= pip_err[i-1];
            end
        end
    end

    // read data payload
    always_ff @(posedge man) begin
        pip_rdt[0] <= rdt_d;
        for (int unsigned i = 1; i < DLY; i++) begin
            pip_rdt[i] <= pip_rdt[i-1];
        end
    end

    // last stage is sampled DLY edges after accept
    assign rsp = '{rdt: pip_rdt[DLY-1], err: pip_err[DLY-1], rdy: rdy_q};

endmodule

//--- src/tcb_lite_subsystem.sv
// TCB lite subsystem top
// response register slice, SRAM subordinate and configuration block

module tcb_lite_subsystem (
    input  logic                  man,
    input  logic                  rst,
    // manager side
    input  tcb_lite_pkg::tcb_req_t req_sub,
    output tcb_lite_pkg::tcb_rsp_t rsp_sub,
    // configuration
    input  logic                  cfg_we,
    input  tcb_lite_pkg::mode_t    cfg_mode,
    input  tcb_lite_pkg::adr_t     cfg_limit,
    output tcb_lite_pkg::cnt_t     err_count
);

    // slice to memory
    tcb_lite_pkg::tcb_req_t req_man;
    tcb_lite_pkg::tcb_rsp_t rsp_man;

    // configuration to datapath
    tcb_lite_pkg::mode_t    mode;
    tcb_lite_pkg::adr_t     limit;
    logic                   rsp_err_pulse;

    tcb_lite_config u_config (
        .man           (man),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_mode      (cfg_mode),
        .cfg_limit     (cfg_limit),
        .rsp_err_pulse (rsp_err_pulse),
        .mode          (mode),
        .limit         (limit),
        .err_count     (err_count)
    );

    // registers the response path only
    tcb_lite_register_response u_slice (
        .man           (man),
        .rst           (rst),
        .req_sub       (req_sub),
        .req_man       (req_man),
        .rsp_man       (rsp_man),
        .rsp_sub       (rsp_sub),
        .mode          (mode),
        .rsp_err_pulse (rsp_err_pulse)
    );

    tcb_lite_memory u_memory (
        .man   (man),
        .rst   (rst),
        .req   (req_man),
        .limit (limit),
        .rsp   (rsp_man)
    );

endmodule

//--- tb/tb_tcb_lite_subsystem.sv
// testbench for the TCB lite subsystem
// random transfers checked against a memory and response model

`include "tcb_lite_consts.svh"

module tb_tcb_lite_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    // about twice the ~1000 cycles that all tests take together
    localparam int unsigned MAX_CYC = 2000;
    // steps from driving a request to seeing its response
    localparam int unsigned LAT = `TCB_DELAY + 1;

    // one expected response, stamped with the step it is due in
    typedef struct packed {
        logic [31:0]        due;
        tcb_lite_pkg::dat_t rdt;
        logic               err;
    } exp_t;

    logic                   man;
    logic                   rst;
    tcb_lite_pkg::tcb_req_t req_sub;
    tcb_lite_pkg::tcb_rsp_t rsp_sub;
    logic                   cfg_we;
    tcb_lite_pkg::mode_t    cfg_mode;
    tcb_lite_pkg::adr_t     cfg_limit;
    tcb_lite_pkg::cnt_t     err_count;

    integer      seed;
    int unsigned cyc;
    int unsigned tick = 0;

    //////////////////////////////
    // reference model state
    //////////////////////////////

    tcb_lite_pkg::dat_t  m_mem [0:`TCB_MEM_WORDS-1];
    // read data the slice should hold
    tcb_lite_pkg::dat_t  m_rdt;
    tcb_lite_pkg::mode_t m_mode;
    tcb_lite_pkg::adr_t  m_limit;
    int unsigned         m_errs;
    exp_t                exp_q [$];

    // per test and overall tallies
    string       cur_test;
    int unsigned test_checks;
    int unsigned test_errs;
    int unsigned all_checks;
    int unsigned all_errs;

    tcb_lite_subsystem uut (
        .man       (man),
        .rst       (rst),
        .req_sub   (req_sub),
        .rsp_sub   (rsp_sub),
        .cfg_we    (cfg_we),
        .cfg_mode  (cfg_mode),
        .cfg_limit (cfg_limit),
        .err_count (err_count)
    );

    // 100 ns period
    always #50 man = ~man;

    // watchdog that ends a stuck run
    always @(posedge man) begin
        tick = tick + 1;
        if (tick >= MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic tcb_lite_pkg::dat_t rand_word();
        return tcb_lite_pkg::dat_t'($random(seed));
    endfunction

    // 32 words at the bottom, so reads hit earlier writes
    function automatic tcb_lite_pkg::adr_t pool_adr();
        return tcb_lite_pkg::adr_t'(rand_below(32'd32) * 32'd4);
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        all_checks++;
        if (act !== exp) begin
            test_errs++;
            all_errs++;
            $display("ERROR %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
        end
    endtask

    // one clock, then check every response due now
    task automatic step();
        exp_t e;
        @(posedge man);
        #5;
        cyc++;
        while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            compare("rdt", e.rdt, rsp_sub.rdt);
            compare("err", 32'(e.err), 32'(rsp_sub.err));
        end
    endtask

    task automatic idle();
        req_sub.vld = 1'b0;
        step();
    endtask

    // wait out the pipeline and one more cycle for the error counter
    task automatic drain();
        while (exp_q.size() > 0) idle();
        idle();
    endtask

    // drive one transfer and predict its response
    task automatic issue(input logic wen, input tcb_lite_pkg::adr_t adr,
                         input tcb_lite_pkg::siz_t siz, input tcb_lite_pkg::byt_t byt,
                         input tcb_lite_pkg::dat_t wdt);
        logic                       over;
        logic [`TCB_ADR_W-3:0]      idx;
        logic                       en;
        exp_t                       e;
        compare("rdy", 32'd1, 32'(rsp_sub.rdy));
        req_sub = '{vld: 1'b1, wen: wen, lck: 1'b0, adr: adr, siz: siz, byt: byt, wdt: wdt};
        over = (adr >= m_limit);
        idx  = adr[`TCB_ADR_W-1:2];
        if (wen) begin
            // blocked writes never reach the array
            if (!over) begin
                for (int b = 0; b < 4; b++) begin
                    if (byt[b]) m_mem[idx][b*8 +: 8] = wdt[b*8 +: 8];
                end
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (m_mode == tcb_lite_pkg::LANE_LOG) en = (b < (1 << siz));
                else en = byt[b];
                // error reads return zero on the enabled lanes
                if (en) m_rdt[b*8 +: 8] = over ? 8'h00 : m_mem[idx][b*8 +: 8];
            end
        end
        if (over) m_errs++;
        e.due = cyc + LAT;
        e.rdt = m_rdt;
        e.err = over;
        exp_q.push_back(e);
        step();
    endtask

    // only touched with the pipeline empty
    task automatic configure(input tcb_lite_pkg::mode_t mode, input tcb_lite_pkg::adr_t limit);
        drain();
        cfg_we    = 1'b1;
        cfg_mode  = mode;
        cfg_limit = limit;
        step();
        cfg_we  = 1'b0;
        m_mode  = mode;
        m_limit = limit;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic end_test();
        drain();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        tcb_lite_pkg::adr_t a;
        tcb_lite_pkg::adr_t lim;
        tcb_lite_pkg::adr_t bad_q [$];
        logic               w;
        seed      = 32'h9c5d_157e;
        man       = 1'b0;
        rst       = 1'b1;
        req_sub   = '0;
        cfg_we    = 1'b0;
        cfg_mode  = tcb_lite_pkg::LANE_LOG;
        cfg_limit = '1;
        m_rdt     = '0;
        m_mode    = tcb_lite_pkg::LANE_LOG;
        m_limit   = '1;
        m_errs    = 0;
        cyc       = 0;
        all_checks = 0;
        all_errs   = 0;
        // memory comes out of reset cleared
        for (int k = 0; k < `TCB_MEM_WORDS; k++) m_mem[k] = '0;

        // reset held for two cycles
        start_test("reset");
        repeat (2) @(posedge man);
        #5;
        rst = 1'b0;
        step();
        compare("rdy", 32'd1, 32'(rsp_sub.rdy));
        compare("err", 32'd0, 32'(rsp_sub.err));
        compare("rdt", 32'd0, rsp_sub.rdt);
        compare("err_count", 32'd0, 32'(err_count));
        end_test();

        // word writes and reads back to back
        start_test("word_rw");
        for (int i = 0; i < 100; i++) begin
            issue(1'b1, pool_adr(), 2'd2, 4'hf, rand_word());
            issue(1'b0, pool_adr(), 2'd2, 4'hf, rand_word());
        end
        end_test();

        // reads of byte, half-word and word size
        start_test("log_size");
        for (int i = 0; i < 150; i++) begin
            w = (rand_below(32'd3) == 0);
            issue(w, pool_adr(), tcb_lite_pkg::siz_t'(rand_below(32'd3)), 4'hf, rand_word());
        end
        end_test();

        // random byte enables on both directions
        start_test("byte_enable");
        configure(tcb_lite_pkg::LANE_BYT, '1);
        for (int i = 0; i < 200; i++) begin
            w = (rand_below(32'd2) == 1);
            issue(w, pool_adr(), 2'd2, tcb_lite_pkg::byt_t'(rand_below(32'd16)), rand_word());
        end
        end_test();

        // addresses straddling a random limit
        start_test("addr_limit");
        lim = tcb_lite_pkg::adr_t'(32'h200 + rand_below(32'h800));
        configure(tcb_lite_pkg::LANE_LOG, lim);
        for (int i = 0; i < 150; i++) begin
            a = tcb_lite_pkg::adr_t'(32'(lim) - 32'h40 + rand_below(32'h80));
            w = (rand_below(32'd2) == 1);
            if (w && a >= lim) bad_q.push_back(a);
            issue(w, a, 2'd2, 4'hf, rand_word());
        end
        // raise the limit and read back where writes were refused
        configure(tcb_lite_pkg::LANE_LOG, '1);
        foreach (bad_q[k]) issue(1'b0, bad_q[k], 2'd2, 4'hf, 32'h0);
        drain();
        compare("err_count", 32'(m_errs), 32'(err_count));
        end_test();

        // reads of written words hold data that the writes between them must keep
        start_test("write_keeps_rdt");
        lim = tcb_lite_pkg::adr_t'(32'h400 + rand_below(32'h400));
        configure(tcb_lite_pkg::LANE_LOG, lim);
        for (int i = 0; i < 50; i++) begin
            issue(1'b0, pool_adr(), 2'd2, 4'hf, rand_word());
            issue(1'b1, tcb_lite_pkg::adr_t'(rand_below(32'h1000)), 2'd2, 4'hf, rand_word());
        end
        drain();
        compare("err_count", 32'(m_errs), 32'(err_count));
        end_test();

        $display("total: %0d checks, %0d errors", all_checks, all_errs);
        if (all_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tcb_lite_subsystem.f
+incdir+src
src/tcb_lite_pkg.sv
src/tcb_lite_config.sv
src/tcb_lite_register_response.sv
src/tcb_lite_memory.sv
src/tcb_lite_subsystem.sv
tb/tb_tcb_lite_subsystem.sv

//--- run.sh
#!/bin/sh
# build and run the TCB lite subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
        -f tcb_lite_subsystem.f \
        --top-module tb_tcb_lite_subsystem \
        -Mdir obj_dir -o sim_tb; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass line only when every check held
if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    echo "run passed"
    exit 0
fi

echo "run failed"
exit 1
